//--- logic/csr_defs.svh
// RV64 machine mode only; misa reports the I extension alone and bits outside the masks read as zero
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// data and address widths
`define CSR_XLEN    64
`define CSR_ADDR_W  12
`define CSR_CAUSE_W 6

// machine trap setup
`define CSR_A_MSTATUS   12'h300
`define CSR_A_MISA      12'h301
`define CSR_A_MIE       12'h304
`define CSR_A_MTVEC     12'h305

// machine trap handling
`define CSR_A_MSCRATCH  12'h340
`define CSR_A_MEPC      12'h341
`define CSR_A_MCAUSE    12'h342
`define CSR_A_MTVAL     12'h343
`define CSR_A_MIP       12'h344

// machine information, all read as zero
`define CSR_A_MVENDORID 12'hF11
`define CSR_A_MARCHID   12'hF12
`define CSR_A_MIMPID    12'hF13
`define CSR_A_MHARTID   12'hF14

// MXL = 2 (RV64), extension I only
`define CSR_MISA_VALUE  64'h8000_0000_0000_0100

// MIE, MPIE and MPP
`define CSR_MSTATUS_WMASK 64'h0000_0000_0000_1888
`define CSR_MIE_WMASK     64'h0000_0000_0000_0888
// bit 1 of mtvec is hardwired to zero
`define CSR_MTVEC_WMASK   64'hFFFF_FFFF_FFFF_FFFD

// mstatus field positions
`define CSR_MSTATUS_MIE  3
`define CSR_MSTATUS_MPIE 7
`define CSR_MSTATUS_MPP  11

// interrupt numbers, same bit in mie and mip
`define CSR_IRQ_MSI 3
`define CSR_IRQ_MTI 7
`define CSR_IRQ_MEI 11
`define CSR_CAUSE_IRQ_BIT 63

`endif

//--- logic/csr_pkg.sv
// types shared by the CSR blocks; operands arrive already zero-extended and nothing ever stalls
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

	// matches the low two bits of funct3
	typedef enum logic [1:0] {
		rw = 2'd1,
		rs = 2'd2,
		rc = 2'd3
	} csr_op_e;

	typedef struct packed {
		logic                   valid;
		csr_op_e                op;
		logic [`CSR_ADDR_W-1:0] addr;
		logic [`CSR_XLEN-1:0]   operand;
		// rs1 == x0 or zero immediate
		logic                   src_zero;
	} csr_req_t;

	typedef struct packed {
		logic                 valid;
		logic                 illegal;
		logic [`CSR_XLEN-1:0] rdata;
	} csr_rsp_t;

	typedef struct packed {
		logic                    exc_valid;
		logic [`CSR_CAUSE_W-1:0] exc_cause;
		logic [`CSR_XLEN-1:0]    exc_pc;
		logic [`CSR_XLEN-1:0]    exc_tval;
		logic                    mret;
		// interrupts only land here
		logic                    boundary_valid;
		logic [`CSR_XLEN-1:0]    boundary_pc;
	} trap_req_t;

	typedef struct packed {
		logic                 take;
		logic                 ret;
		logic [`CSR_XLEN-1:0] mstatus_new;
		logic [`CSR_XLEN-1:0] mepc_new;
		logic [`CSR_XLEN-1:0] mcause_new;
		logic [`CSR_XLEN-1:0] mtval_new;
	} trap_update_t;

	typedef struct packed {
		logic                   we;
		logic [`CSR_ADDR_W-1:0] addr;
		logic [`CSR_XLEN-1:0]   wdata;
	} csr_wr_t;

	typedef struct packed {
		logic                 valid;
		logic [`CSR_XLEN-1:0] pc;
	} redirect_t;

	typedef struct packed {
		logic [`CSR_XLEN-1:0] mstatus;
		logic [`CSR_XLEN-1:0] mie;
		logic [`CSR_XLEN-1:0] mip;
		logic [`CSR_XLEN-1:0] mtvec;
		logic [`CSR_XLEN-1:0] mepc;
	} trap_view_t;

endpackage

`default_nettype wire

//--- logic/csr_exec.sv
// CSR instruction execute; every valid request is answered one cycle later, illegal ones with zero
`default_nettype none

`include "csr_defs.svh"

module csr_exec (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  csr_pkg::csr_req_t      csr_req,
	output logic [`CSR_ADDR_W-1:0] csr_addr,
	input  logic [`CSR_XLEN-1:0]   rdata_raw,
	input  logic                   hit,
	input  logic                   read_only,
	output csr_pkg::csr_wr_t       csr_wr,
	output csr_pkg::csr_rsp_t      csr_rsp
);

	logic [`CSR_XLEN-1:0] wdata;
	logic                 wr_intent;
	logic                 illegal;
	logic                 rsp_valid;
	logic                 rsp_illegal;
	logic [`CSR_XLEN-1:0] rsp_rdata;

	// read side goes straight to the register file
	assign csr_addr = csr_req.addr;

	always_comb begin
		case (csr_req.op)
			csr_pkg::rs: wdata = rdata_raw | csr_req.operand;
			csr_pkg::rc: wdata = rdata_raw & ~csr_req.operand;
			default:     wdata = csr_req.operand;
		endcase
	end

	// set or clear with a zero source is a pure read
	assign wr_intent = csr_req.valid & ~((csr_req.op != csr_pkg::rw) & csr_req.src_zero);
	assign illegal   = csr_req.valid & (~hit | (wr_intent & read_only));

	always_comb begin
		csr_wr.we    = wr_intent & ~illegal;
		csr_wr.addr  = csr_req.addr;
		csr_wr.wdata = wdata;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			rsp_valid   <= 1'b0;
			rsp_illegal <= 1'b0;
		end else begin
			rsp_valid   <= csr_req.valid;
			rsp_illegal <= illegal;
		end
	end

	// old value, captured before this request's write lands
	always_ff @(posedge CLK) begin
		if (csr_req.valid) begin
			rsp_rdata <= illegal ? '0 : rdata_raw;
		end
	end

	always_comb begin
		csr_rsp.valid   = rsp_valid;
		csr_rsp.illegal = rsp_illegal;
		csr_rsp.rdata   = rsp_rdata;
	end

endmodule

`default_nettype wire

//--- logic/trap_ctrl.sv
// machine-mode trap entry and MRET; no delegation, MPP is always 3 and vectored mode affects interrupts only
`default_nettype none

`include "csr_defs.svh"

module trap_ctrl (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  csr_pkg::trap_req_t       trap_req,
	input  csr_pkg::trap_view_t      trap_view,
	output csr_pkg::trap_update_t    trap_upd,
	output csr_pkg::redirect_t       redirect
);

	logic [`CSR_XLEN-1:0]    pending;
	logic                    irq_any;
	logic [`CSR_CAUSE_W-1:0] irq_code;
	logic                    take_exc;
	logic                    take_ret;
	logic                    take_irq;
	logic [`CSR_XLEN-1:0]    tvec_base;
	logic [`CSR_XLEN-1:0]    irq_offset;
	logic [`CSR_XLEN-1:0]    next_pc;
	logic [`CSR_XLEN-1:0]    mst_old;
	logic [`CSR_XLEN-1:0]    mst_new;
	logic                    redir_valid;
	logic [`CSR_XLEN-1:0]    redir_pc;

	// external, then software, then timer
	always_comb begin
		pending  = trap_view.mie & trap_view.mip;
		irq_any  = 1'b1;
		irq_code = '0;
		if (pending[`CSR_IRQ_MEI]) begin
			irq_code = `CSR_CAUSE_W'(`CSR_IRQ_MEI);
		end else if (pending[`CSR_IRQ_MSI]) begin
			irq_code = `CSR_CAUSE_W'(`CSR_IRQ_MSI);
		end else if (pending[`CSR_IRQ_MTI]) begin
			irq_code = `CSR_CAUSE_W'(`CSR_IRQ_MTI);
		end else begin
			irq_any = 1'b0;
		end
	end

	assign mst_old = trap_view.mstatus;

	// exception over MRET over interrupt
	assign take_exc = trap_req.exc_valid;
	assign take_ret = trap_req.mret & ~trap_req.exc_valid;
	assign take_irq = trap_req.boundary_valid & mst_old[`CSR_MSTATUS_MIE] & irq_any
		& ~trap_req.exc_valid & ~trap_req.mret;

	always_comb begin
		mst_new = mst_old;
		if (take_exc | take_irq) begin
			mst_new[`CSR_MSTATUS_MPIE]     = mst_old[`CSR_MSTATUS_MIE];
			mst_new[`CSR_MSTATUS_MIE]      = 1'b0;
			mst_new[`CSR_MSTATUS_MPP +: 2] = 2'b11;
		end else if (take_ret) begin
			mst_new[`CSR_MSTATUS_MIE]  = mst_old[`CSR_MSTATUS_MPIE];
			mst_new[`CSR_MSTATUS_MPIE] = 1'b1;
		end
	end

	always_comb begin
		trap_upd.take        = take_exc | take_irq;
		trap_upd.ret         = take_ret;
		trap_upd.mstatus_new = mst_new;
		trap_upd.mepc_new    = take_exc ? trap_req.exc_pc : trap_req.boundary_pc;
		trap_upd.mcause_new  = '0;
		trap_upd.mtval_new   = '0;
		if (take_exc) begin
			trap_upd.mcause_new[`CSR_CAUSE_W-1:0] = trap_req.exc_cause;
			trap_upd.mtval_new                    = trap_req.exc_tval;
		end else begin
			trap_upd.mcause_new[`CSR_CAUSE_W-1:0] = irq_code;
			trap_upd.mcause_new[`CSR_CAUSE_IRQ_BIT] = 1'b1;
		end
	end

	// mode lives in bit 0, bit 1 is always zero
	assign tvec_base  = {trap_view.mtvec[`CSR_XLEN-1:2], 2'b00};
	assign irq_offset = {{(`CSR_XLEN-`CSR_CAUSE_W-2){1'b0}}, irq_code, 2'b00};

	always_comb begin
		if (take_ret) begin
			next_pc = trap_view.mepc;
		end else if (take_irq && trap_view.mtvec[0]) begin
			next_pc = tvec_base + irq_offset;
		end else begin
			next_pc = tvec_base;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			redir_valid <= 1'b0;
		end else begin
			redir_valid <= take_exc | take_irq | take_ret;
		end
	end

	always_ff @(posedge CLK) begin
		redir_pc <= next_pc;
	end

	always_comb begin
		redirect.valid = redir_valid;
		redirect.pc    = redir_pc;
	end

endmodule

`default_nettype wire

//--- logic/csr_file.sv
// machine CSR storage; mip mirrors the interrupt lines one cycle late and a trap blocks every instruction write
`default_nettype none

`include "csr_defs.svh"

module csr_file (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic [`CSR_ADDR_W-1:0] csr_addr,
	output logic [`CSR_XLEN-1:0]   rdata_raw,
	output logic                   hit,
	output logic                   read_only,
	input  csr_pkg::csr_wr_t       csr_wr,
	input  csr_pkg::trap_update_t  trap_upd,
	input  logic                   ext_irq,
	input  logic                   timer_irq,
	input  logic                   soft_irq,
	output csr_pkg::trap_view_t    trap_view
);

	logic [`CSR_XLEN-1:0] mstatus;
	logic [`CSR_XLEN-1:0] mie;
	logic [`CSR_XLEN-1:0] mtvec;
	logic [`CSR_XLEN-1:0] mscratch;
	logic [`CSR_XLEN-1:0] mepc;
	logic [`CSR_XLEN-1:0] mcause;
	logic [`CSR_XLEN-1:0] mtval;
	logic [`CSR_XLEN-1:0] mip;
	logic [`CSR_XLEN-1:0] irq_lines;

	function automatic logic [`CSR_XLEN-1:0] merge(
		input logic [`CSR_XLEN-1:0] old_val,
		input logic [`CSR_XLEN-1:0] new_val,
		input logic [`CSR_XLEN-1:0] mask
	);
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	always_comb begin
		irq_lines               = '0;
		irq_lines[`CSR_IRQ_MEI] = ext_irq;
		irq_lines[`CSR_IRQ_MTI] = timer_irq;
		irq_lines[`CSR_IRQ_MSI] = soft_irq;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mstatus  <= '0;
			mie      <= '0;
			mtvec    <= '0;
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mtval    <= '0;
			mip      <= '0;
		end else begin
			mip <= irq_lines;
			if (trap_upd.take | trap_upd.ret) begin
				// instruction write in this cycle is lost
				mstatus <= trap_upd.mstatus_new;
				if (trap_upd.take) begin
					mepc   <= trap_upd.mepc_new;
					mcause <= trap_upd.mcause_new;
					mtval  <= trap_upd.mtval_new;
				end
			end else if (csr_wr.we) begin
				case (csr_wr.addr)
					`CSR_A_MSTATUS: begin
						mstatus <= merge(mstatus, csr_wr.wdata, `CSR_MSTATUS_WMASK);
					end
					`CSR_A_MIE: begin
						mie <= merge(mie, csr_wr.wdata, `CSR_MIE_WMASK);
					end
					`CSR_A_MTVEC: begin
						mtvec <= merge(mtvec, csr_wr.wdata, `CSR_MTVEC_WMASK);
					end
					`CSR_A_MSCRATCH: mscratch <= csr_wr.wdata;
					`CSR_A_MEPC:     mepc     <= csr_wr.wdata;
					`CSR_A_MCAUSE:   mcause   <= csr_wr.wdata;
					`CSR_A_MTVAL:    mtval    <= csr_wr.wdata;
					default: begin
					end
				endcase
			end
		end
	end

	// read decode
	always_comb begin
		rdata_raw = '0;
		hit       = 1'b1;
		read_only = 1'b0;
		case (csr_addr)
			`CSR_A_MSTATUS:  rdata_raw = mstatus;
			`CSR_A_MIE:      rdata_raw = mie;
			`CSR_A_MTVEC:    rdata_raw = mtvec;
			`CSR_A_MSCRATCH: rdata_raw = mscratch;
			`CSR_A_MEPC:     rdata_raw = mepc;
			`CSR_A_MCAUSE:   rdata_raw = mcause;
			`CSR_A_MTVAL:    rdata_raw = mtval;
			`CSR_A_MISA: begin
				rdata_raw = `CSR_MISA_VALUE;
				read_only = 1'b1;
			end
			`CSR_A_MIP: begin
				rdata_raw = mip;
				read_only = 1'b1;
			end
			`CSR_A_MVENDORID, `CSR_A_MARCHID, `CSR_A_MIMPID, `CSR_A_MHARTID: begin
				read_only = 1'b1;
			end
			default: hit = 1'b0;
		endcase
	end

	always_comb begin
		trap_view.mstatus = mstatus;
		trap_view.mie     = mie;
		trap_view.mip     = mip;
		trap_view.mtvec   = mtvec;
		trap_view.mepc    = mepc;
	end

endmodule

`default_nettype wire

//--- logic/csr_unit.sv
// machine CSR block top; single-cycle requests with no back-pressure, a trap wins over a CSR write
`default_nettype none

`include "csr_defs.svh"

module csr_unit (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  csr_pkg::csr_req_t    csr_req,
	input  csr_pkg::trap_req_t   trap_req,
	input  logic                 ext_irq,
	input  logic                 timer_irq,
	input  logic                 soft_irq,
	output csr_pkg::csr_rsp_t    csr_rsp,
	output csr_pkg::redirect_t   redirect
);

	logic [`CSR_ADDR_W-1:0]  csr_addr;
	logic [`CSR_XLEN-1:0]    rdata_raw;
	logic                    hit;
	logic                    read_only;
	csr_pkg::csr_wr_t        csr_wr;
	csr_pkg::trap_update_t   trap_upd;
	csr_pkg::trap_view_t     trap_view;

	csr_exec i_csr_exec (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.csr_req   (csr_req),
		.csr_addr  (csr_addr),
		.rdata_raw (rdata_raw),
		.hit       (hit),
		.read_only (read_only),
		.csr_wr    (csr_wr),
		.csr_rsp   (csr_rsp)
	);

	trap_ctrl i_trap_ctrl (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.trap_req  (trap_req),
		.trap_view (trap_view),
		.trap_upd  (trap_upd),
		.redirect  (redirect)
	);

	csr_file i_csr_file (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.csr_addr  (csr_addr),
		.rdata_raw (rdata_raw),
		.hit       (hit),
		.read_only (read_only),
		.csr_wr    (csr_wr),
		.trap_upd  (trap_upd),
		.ext_irq   (ext_irq),
		.timer_irq (timer_irq),
		.soft_irq  (soft_irq),
		.trap_view (trap_view)
	);

endmodule

`default_nettype wire

//--- sim/tb_csr_unit.sv
// each table row takes two clock cycles, one active and one idle; expected values come from an in-bench CSR model
`default_nettype none

`include "csr_defs.svh"

module tb_csr_unit;

	localparam int PERIOD = 40;
	localparam logic [1:0] K_EXC = 2'd0;
	localparam logic [1:0] K_MRET = 2'd1;
	localparam logic [1:0] K_IRQ = 2'd2;

	typedef struct packed {
		csr_pkg::csr_req_t  req;
		csr_pkg::trap_req_t trap;
		// ext, timer, soft
		logic [2:0]         irq;
		csr_pkg::csr_rsp_t  exp_rsp;
		csr_pkg::redirect_t exp_redir;
	} row_t;

	logic               CLK;
	logic               rst_n;
	csr_pkg::csr_req_t  csr_req;
	csr_pkg::trap_req_t trap_req;
	logic               ext_irq;
	logic               timer_irq;
	logic               soft_irq;
	csr_pkg::csr_rsp_t  csr_rsp;
	csr_pkg::redirect_t redirect;

	row_t       rows[$];
	string      names[$];
	int         table_len = 0;
	integer     seed = 30;
	logic [2:0] cur_irq;
	int         row_errs;
	int         passed;
	int         failed;

	// reference copy of the machine registers
	logic [63:0] m_mstatus;
	logic [63:0] m_mie;
	logic [63:0] m_mtvec;
	logic [63:0] m_mscratch;
	logic [63:0] m_mepc;
	logic [63:0] m_mcause;
	logic [63:0] m_mtval;
	logic [63:0] m_mip;

	csr_unit i_csr_unit (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.csr_req   (csr_req),
		.trap_req  (trap_req),
		.ext_irq   (ext_irq),
		.timer_irq (timer_irq),
		.soft_irq  (soft_irq),
		.csr_rsp   (csr_rsp),
		.redirect  (redirect)
	);

	always begin
		#(PERIOD / 2);
		CLK = ~CLK;
	end

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic csr_pkg::csr_req_t make_req(input csr_pkg::csr_op_e op,
		input logic [11:0] addr, input logic [63:0] opnd, input logic sz);
		csr_pkg::csr_req_t r;
		r.valid    = 1'b1;
		r.op       = op;
		r.addr     = addr;
		r.operand  = opnd;
		r.src_zero = sz;
		return r;
	endfunction

	function automatic csr_pkg::trap_req_t make_trap(input logic [1:0] kind, input logic [63:0] pc);
		csr_pkg::trap_req_t t;
		t                = '0;
		t.exc_valid      = (kind == K_EXC);
		// illegal instruction
		t.exc_cause      = 6'd2;
		// the pc field that does not apply carries a different value
		t.exc_pc         = (kind == K_EXC) ? pc : {pc[31:0], pc[63:32]};
		t.exc_tval       = ~pc;
		t.mret           = (kind == K_MRET);
		t.boundary_valid = (kind == K_IRQ);
		t.boundary_pc    = (kind == K_EXC) ? {pc[31:0], pc[63:32]} : pc;
		return t;
	endfunction

	function automatic logic [63:0] csr_value(input logic [11:0] addr);
		case (addr)
			`CSR_A_MSTATUS:  return m_mstatus;
			`CSR_A_MISA:     return `CSR_MISA_VALUE;
			`CSR_A_MIE:      return m_mie;
			`CSR_A_MTVEC:    return m_mtvec;
			`CSR_A_MSCRATCH: return m_mscratch;
			`CSR_A_MEPC:     return m_mepc;
			`CSR_A_MCAUSE:   return m_mcause;
			`CSR_A_MTVAL:    return m_mtval;
			`CSR_A_MIP:      return m_mip;
			default:         return 64'd0;
		endcase
	endfunction

	function automatic logic known_addr(input logic [11:0] addr);
		case (addr)
			`CSR_A_MSTATUS, `CSR_A_MISA, `CSR_A_MIE, `CSR_A_MTVEC, `CSR_A_MSCRATCH: return 1'b1;
			`CSR_A_MEPC, `CSR_A_MCAUSE, `CSR_A_MTVAL, `CSR_A_MIP: return 1'b1;
			`CSR_A_MVENDORID, `CSR_A_MARCHID, `CSR_A_MIMPID, `CSR_A_MHARTID: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// bits outside the masks never become set, so masking the new value is enough
	task automatic store_value(input logic [11:0] addr, input logic [63:0] v);
		case (addr)
			`CSR_A_MSTATUS:  m_mstatus  = v & `CSR_MSTATUS_WMASK;
			`CSR_A_MIE:      m_mie      = v & `CSR_MIE_WMASK;
			`CSR_A_MTVEC:    m_mtvec    = v & `CSR_MTVEC_WMASK;
			`CSR_A_MSCRATCH: m_mscratch = v;
			`CSR_A_MEPC:     m_mepc     = v;
			`CSR_A_MCAUSE:   m_mcause   = v;
			`CSR_A_MTVAL:    m_mtval    = v;
			default: ;
		endcase
	endtask

	task automatic add_row(input string name, input csr_pkg::csr_req_t req,
		input csr_pkg::trap_req_t trap);
		row_t        r;
		logic [63:0] old;
		logic [63:0] pend;
		logic [63:0] base;
		logic [5:0]  code;
		logic        wr;
		logic        ro;
		logic        irq_take;
		r     = '0;
		r.req  = req;
		r.trap = trap;
		r.irq  = cur_irq;
		old    = csr_value(req.addr);
		wr     = (req.op == csr_pkg::rw) || !req.src_zero;
		ro     = (req.addr == `CSR_A_MISA) || (req.addr == `CSR_A_MIP) || (req.addr[11:8] == 4'hF);
		r.exp_rsp.valid   = req.valid;
		r.exp_rsp.illegal = req.valid && (!known_addr(req.addr) || (wr && ro));
		r.exp_rsp.rdata   = r.exp_rsp.illegal ? 64'd0 : old;
		// exception first, then MRET, then an enabled interrupt
		pend     = m_mie & m_mip;
		code     = pend[11] ? 6'd11 : (pend[3] ? 6'd3 : 6'd7);
		irq_take = trap.boundary_valid && m_mstatus[3] && (|pend) && !trap.exc_valid && !trap.mret;
		base     = {m_mtvec[63:2], 2'b00};
		r.exp_redir.valid = trap.exc_valid || trap.mret || irq_take;
		if (trap.exc_valid || irq_take) begin
			r.exp_redir.pc = (irq_take && m_mtvec[0]) ? base + 4 * code : base;
			m_mstatus = 64'h1800 | (m_mstatus[3] ? 64'h80 : 64'h0);
			m_mepc    = trap.exc_valid ? trap.exc_pc : trap.boundary_pc;
			m_mcause  = trap.exc_valid ? {58'd0, trap.exc_cause} : {1'b1, 57'd0, code};
			m_mtval   = trap.exc_valid ? trap.exc_tval : 64'd0;
		end else if (trap.mret) begin
			r.exp_redir.pc = m_mepc;
			m_mstatus = {m_mstatus[63:8], 1'b1, m_mstatus[6:4], m_mstatus[7], m_mstatus[2:0]};
		end else if (req.valid && wr && !r.exp_rsp.illegal) begin
			store_value(req.addr, req.op == csr_pkg::rs ? old | req.operand :
				(req.op == csr_pkg::rc ? old & ~req.operand : req.operand));
		end
		// lines show up in mip one cycle later
		m_mip = {52'd0, cur_irq[2], 3'd0, cur_irq[1], 3'd0, cur_irq[0], 3'd0};
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic csr_access(input string name, input csr_pkg::csr_op_e op,
		input logic [11:0] addr, input logic [63:0] opnd, input logic sz);
		add_row(name, make_req(op, addr, opnd, sz), '0);
	endtask

	task automatic read_csr(input string name, input logic [11:0] addr);
		csr_access(name, csr_pkg::rs, addr, 64'd0, 1'b1);
	endtask

	task automatic trap_only(input string name, input logic [1:0] kind, input logic [63:0] pc);
		add_row(name, '0, make_trap(kind, pc));
	endtask

	task automatic build_table();
		logic [63:0] base;
		cur_irq = 3'b000;
		read_csr("misa after reset", `CSR_A_MISA);
		read_csr("mvendorid after reset", `CSR_A_MVENDORID);
		read_csr("marchid after reset", `CSR_A_MARCHID);
		read_csr("mimpid after reset", `CSR_A_MIMPID);
		read_csr("mhartid after reset", `CSR_A_MHARTID);
		read_csr("mstatus after reset", `CSR_A_MSTATUS);
		read_csr("mtvec after reset", `CSR_A_MTVEC);
		read_csr("mepc after reset", `CSR_A_MEPC);
		read_csr("mcause after reset", `CSR_A_MCAUSE);
		read_csr("mtval after reset", `CSR_A_MTVAL);
		csr_access("rw mscratch", csr_pkg::rw, `CSR_A_MSCRATCH, rand64(), 1'b0);
		csr_access("rs mscratch", csr_pkg::rs, `CSR_A_MSCRATCH, rand64(), 1'b0);
		csr_access("rc mscratch", csr_pkg::rc, `CSR_A_MSCRATCH, rand64(), 1'b0);
		csr_access("rs mscratch src zero", csr_pkg::rs, `CSR_A_MSCRATCH, rand64(), 1'b1);
		csr_access("rc mscratch src zero", csr_pkg::rc, `CSR_A_MSCRATCH, rand64(), 1'b1);
		read_csr("mscratch readback", `CSR_A_MSCRATCH);
		csr_access("rw mie", csr_pkg::rw, `CSR_A_MIE, '1, 1'b0);
		csr_access("rc mie", csr_pkg::rc, `CSR_A_MIE, 64'h8, 1'b0);
		csr_access("rw mtvec", csr_pkg::rw, `CSR_A_MTVEC, rand64(), 1'b0);
		read_csr("mtvec readback", `CSR_A_MTVEC);
		csr_access("unknown address", csr_pkg::rw, 12'h7C0, rand64(), 1'b0);
		csr_access("write misa", csr_pkg::rw, `CSR_A_MISA, rand64(), 1'b0);
		cur_irq = 3'b101;
		csr_access("write mip", csr_pkg::rs, `CSR_A_MIP, rand64(), 1'b0);
		read_csr("read mip", `CSR_A_MIP);
		base = rand64() & ~64'h3;
		csr_access("mtvec direct", csr_pkg::rw, `CSR_A_MTVEC, base, 1'b0);
		csr_access("set mstatus.MIE", csr_pkg::rw, `CSR_A_MSTATUS, 64'h8, 1'b0);
		add_row("exception with write", make_req(csr_pkg::rw, `CSR_A_MSCRATCH, rand64(), 1'b0),
			make_trap(K_EXC, rand64()));
		read_csr("mepc after exception", `CSR_A_MEPC);
		read_csr("mcause after exception", `CSR_A_MCAUSE);
		read_csr("mtval after exception", `CSR_A_MTVAL);
		read_csr("mstatus after exception", `CSR_A_MSTATUS);
		read_csr("mscratch kept", `CSR_A_MSCRATCH);
		trap_only("mret", K_MRET, 64'd0);
		read_csr("mstatus after mret", `CSR_A_MSTATUS);
		csr_access("clear mstatus", csr_pkg::rw, `CSR_A_MSTATUS, 64'd0, 1'b0);
		trap_only("boundary with MIE clear", K_IRQ, rand64());
		csr_access("set MIE again", csr_pkg::rw, `CSR_A_MSTATUS, 64'h8, 1'b0);
		trap_only("external, direct", K_IRQ, rand64());
		read_csr("mcause after interrupt", `CSR_A_MCAUSE);
		read_csr("mtval after interrupt", `CSR_A_MTVAL);
		trap_only("mret from external", K_MRET, 64'd0);
		csr_access("mtvec vectored", csr_pkg::rw, `CSR_A_MTVEC, base | 64'h1, 1'b0);
		trap_only("exception, vectored", K_EXC, rand64());
		trap_only("mret from exception", K_MRET, 64'd0);
		csr_access("mie soft and timer", csr_pkg::rw, `CSR_A_MIE, 64'h88, 1'b0);
		trap_only("software, vectored", K_IRQ, rand64());
		cur_irq = 3'b011;
		trap_only("mret from software", K_MRET, 64'd0);
		csr_access("mie all", csr_pkg::rw, `CSR_A_MIE, 64'h888, 1'b0);
		trap_only("software over timer", K_IRQ, rand64());
		cur_irq = 3'b111;
		trap_only("mret, all lines high", K_MRET, 64'd0);
		trap_only("external over all", K_IRQ, rand64());
		cur_irq = 3'b010;
		trap_only("mret, timer line only", K_MRET, 64'd0);
		trap_only("timer alone", K_IRQ, rand64());
		read_csr("mcause after timer", `CSR_A_MCAUSE);
		cur_irq = 3'b000;
		trap_only("mret, lines low", K_MRET, 64'd0);
		trap_only("boundary, nothing pending", K_IRQ, rand64());
	endtask

	task automatic report_mismatch(input int idx, input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		$display("** Error row %0d (%s): %s = %h, expected %h", idx, names[idx], sig, got, exp);
		row_errs++;
	endtask

	initial begin
		row_t cur;
		CLK       = 1'b0;
		rst_n     = 1'b0;
		csr_req   = '0;
		trap_req  = '0;
		ext_irq   = 1'b0;
		timer_irq = 1'b0;
		soft_irq  = 1'b0;
		passed    = 0;
		failed    = 0;
		m_mstatus  = '0;
		m_mie      = '0;
		m_mtvec    = '0;
		m_mscratch = '0;
		m_mepc     = '0;
		m_mcause   = '0;
		m_mtval    = '0;
		m_mip      = '0;
		build_table();
		table_len = rows.size();
		repeat (3) @(posedge CLK);
		rst_n <= 1'b1;
		foreach (rows[i]) begin
			cur      = rows[i];
			row_errs = 0;
			@(posedge CLK);
			csr_req <= cur.req;
			trap_req <= cur.trap;
			{ext_irq, timer_irq, soft_irq} <= cur.irq;
			// outputs here belong to the idle cycle before this row
			@(negedge CLK);
			if (csr_rsp.valid !== 1'b0) begin
				report_mismatch(i, "csr_rsp.valid before row", csr_rsp.valid, 64'd0);
			end
			if (redirect.valid !== 1'b0) begin
				report_mismatch(i, "redirect.valid before row", redirect.valid, 64'd0);
			end
			@(posedge CLK);
			csr_req <= '0;
			trap_req <= '0;
			@(negedge CLK);
			if (csr_rsp.valid !== cur.exp_rsp.valid) begin
				report_mismatch(i, "csr_rsp.valid", csr_rsp.valid, cur.exp_rsp.valid);
			end
			if (cur.exp_rsp.valid && csr_rsp.illegal !== cur.exp_rsp.illegal) begin
				report_mismatch(i, "csr_rsp.illegal", csr_rsp.illegal, cur.exp_rsp.illegal);
			end
			if (cur.exp_rsp.valid && csr_rsp.rdata !== cur.exp_rsp.rdata) begin
				report_mismatch(i, "csr_rsp.rdata", csr_rsp.rdata, cur.exp_rsp.rdata);
			end
			if (redirect.valid !== cur.exp_redir.valid) begin
				report_mismatch(i, "redirect.valid", redirect.valid, cur.exp_redir.valid);
			end
			if (cur.exp_redir.valid && redirect.pc !== cur.exp_redir.pc) begin
				report_mismatch(i, "redirect.pc", redirect.pc, cur.exp_redir.pc);
			end
			if (row_errs == 0) begin
				passed++;
				$display("row %0d %s: ok", i, names[i]);
			end else begin
				failed++;
				$display("row %0d %s: %0d mismatches", i, names[i], row_errs);
			end
		end
		$display("rows %0d, passed %0d, failed %0d", table_len, passed, failed);
		if (failed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// generous bound: two cycles per row are used, four are allowed
	initial begin
		wait (table_len > 0);
		#((table_len * 4 + 3) * PERIOD);
		$display("watchdog expired before the table finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- csr_unit.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_exec.sv
logic/trap_ctrl.sv
logic/csr_file.sv
logic/csr_unit.sv
sim/tb_csr_unit.sv
